//--- hw/fetch_pkg.sv
package fetch_pkg;

    ////////////////////
    // Sizes

    // Word and address width
    localparam int xlen = 32;

    // Scratch memory depth in words
    localparam int scratch_words = 256;

    // Main memory depth in words
    localparam int main_mem_words = 1024;

    // Cache geometry
    localparam int line_words = 4;
    localparam int cache_lines = 16;

    // Instruction buffer depth
    localparam int fetch_buf_depth = 4;

    // Cycles from a granted read to the first word
    localparam int mem_read_latency = 2;

    ////////////////////
    // Address map

    // First fetch after reset, lands in scratch space
    localparam logic [xlen-1:0] reset_vec = 32'h0000_0100;

    // Set selects the cache, clear selects scratch
    localparam int cache_region_bit = 31;

    ////////////////////
    // Types

    // 0 for scratch, 1 for cache
    typedef logic unit_id_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
    } fetch_entry_t;

endpackage

//--- hw/fifo_buffer.sv
module fifo_buffer #(
    parameter type payload_t = logic,
    parameter int depth = 2
) (
    input  logic     clk,
    input  logic     flush_or_rst,
    input  logic     push,
    input  logic     pop,
    input  payload_t data_in,
    output payload_t data_out,
    output logic     valid
);
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t store [depth];
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [cnt_w-1:0] count;
    logic do_push;
    logic do_pop;

    assign valid = (count != '0);
    assign do_pop = pop & valid;
    // Full FIFO still takes a word when the oldest leaves this cycle
    assign do_push = push & ((count != cnt_w'(depth)) | do_pop);
    assign data_out = store[rd_ptr];

    always_ff @(posedge clk) begin
        if (flush_or_rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + cnt_w'(do_push) - cnt_w'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            store[wr_ptr] <= data_in;
        end
    end

endmodule

//--- hw/iscratch_mem.sv
module iscratch_mem (
    input  logic                       clk,
    input  logic                       flush_or_rst,
    input  logic                       request,
    input  logic [fetch_pkg::xlen-1:0] addr,
    output logic                       ready,
    output logic                       data_valid,
    output logic [fetch_pkg::xlen-1:0] data_out,
    input  logic                       load_we,
    input  logic [fetch_pkg::xlen-1:0] load_addr,
    input  logic [fetch_pkg::xlen-1:0] load_data
);
    import fetch_pkg::*;

    localparam int word_aw = $clog2(scratch_words);

    logic [xlen-1:0] mem [scratch_words];

    // Single cycle, never stalls
    assign ready = 1'b1;

    always_ff @(posedge clk) begin
        if (flush_or_rst) begin
            data_valid <= 1'b0;
        end else begin
            data_valid <= request;
        end
    end

    // Fetch read and loader write, addresses wrap at scratch depth
    always_ff @(posedge clk) begin
        if (request) begin
            data_out <= mem[addr[word_aw+1:2]];
        end
        if (load_we) begin
            mem[load_addr[word_aw+1:2]] <= load_data;
        end
    end

endmodule

//--- hw/icache.sv
module icache (
    input  logic                       clk,
    input  logic                       flush_or_rst,
    input  logic                       redirect,
    input  logic                       request,
    input  logic [fetch_pkg::xlen-1:0] addr,
    output logic                       ready,
    output logic                       data_valid,
    output logic [fetch_pkg::xlen-1:0] data_out,
    output logic                       bus_req,
    output logic [fetch_pkg::xlen-1:0] bus_addr,
    input  logic                       bus_gnt,
    input  logic                       rvalid,
    input  logic [fetch_pkg::xlen-1:0] rdata
);
    import fetch_pkg::*;

    localparam int off_w = $clog2(line_words);
    localparam int idx_w = $clog2(cache_lines);
    localparam int line_lsb = 2 + off_w;
    localparam int tag_lsb = line_lsb + idx_w;
    localparam int tag_w = xlen - tag_lsb;

    typedef enum logic [1:0] {s_idle, s_req, s_wait, s_fill} state_t;

    state_t state;
    logic [tag_w-1:0] tag_arr [cache_lines];
    logic [xlen-1:0] data_arr [cache_lines * line_words];
    logic [cache_lines-1:0] line_valid;

    logic [idx_w-1:0] req_idx;
    logic [off_w-1:0] req_off;
    logic hit;
    logic miss_start;
    logic [xlen-1:0] miss_addr;
    logic [off_w-1:0] fill_cnt;
    logic fill_we;
    logic fill_last;
    logic discard;

    ////////////////////
    // Lookup

    assign req_idx = addr[tag_lsb-1:line_lsb];
    assign req_off = addr[line_lsb-1:2];
    assign hit = line_valid[req_idx] && (tag_arr[req_idx] == addr[xlen-1:tag_lsb]);
    assign miss_start = request && ready && !hit;

    assign ready = (state == s_idle);
    assign bus_req = (state == s_req);
    assign bus_addr = {miss_addr[xlen-1:line_lsb], line_lsb'(0)};

    // Words arrive in line order starting at offset zero
    assign fill_we = rvalid && ((state == s_wait) || (state == s_fill));
    assign fill_last = fill_we && (fill_cnt == off_w'(line_words - 1));

    ////////////////////
    // Miss FSM

    always_ff @(posedge clk) begin
        if (flush_or_rst) begin
            state <= s_idle;
            data_valid <= 1'b0;
            line_valid <= '0;
            fill_cnt <= '0;
            discard <= 1'b0;
        end else begin
            data_valid <= 1'b0;
            case (state)
                s_idle: begin
                    if (request && hit) begin
                        data_valid <= 1'b1;
                    end else if (request) begin
                        // Line is overwritten during the fill
                        line_valid[req_idx] <= 1'b0;
                        state <= s_req;
                    end
                end
                s_req: begin
                    fill_cnt <= '0;
                    if (bus_gnt) begin
                        state <= s_wait;
                    end
                end
                s_wait: begin
                    if (rvalid) begin
                        state <= s_fill;
                    end
                end
                default: begin
                    if (fill_last) begin
                        line_valid[miss_addr[tag_lsb-1:line_lsb]] <= 1'b1;
                        data_valid <= !discard && !redirect;
                        state <= s_idle;
                    end
                end
            endcase
            if (fill_we) begin
                fill_cnt <= fill_cnt + 1'b1;
            end
            // A redirect during a miss drops the word once the fill ends
            if (fill_last) begin
                discard <= 1'b0;
            end else if (redirect && (state != s_idle)) begin
                discard <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (miss_start) begin
            miss_addr <= addr;
            tag_arr[req_idx] <= addr[xlen-1:tag_lsb];
        end
        if (fill_we) begin
            data_arr[{miss_addr[tag_lsb-1:line_lsb], fill_cnt}] <= rdata;
        end
        if (request && ready && hit) begin
            data_out <= data_arr[{req_idx, req_off}];
        end else if (fill_we && (fill_cnt == miss_addr[line_lsb-1:2])) begin
            data_out <= rdata;
        end
    end

endmodule

//--- hw/mem_arbiter.sv
module mem_arbiter (
    input  logic                       clk,
    input  logic                       flush_or_rst,
    input  logic                       req_c,
    input  logic [fetch_pkg::xlen-1:0] addr_c,
    output logic                       gnt_c,
    input  logic                       req_l,
    input  logic [fetch_pkg::xlen-1:0] addr_l,
    input  logic [fetch_pkg::xlen-1:0] wdata_l,
    output logic                       gnt_l,
    output logic                       mem_req,
    output logic                       mem_we,
    output logic [fetch_pkg::xlen-1:0] mem_addr,
    output logic [fetch_pkg::xlen-1:0] mem_wdata,
    input  logic                       mem_rvalid
);
    import fetch_pkg::*;

    localparam int busy_w = $clog2(line_words) + 1;

    // Set when the loader won the last grant
    logic last_l;
    logic [busy_w-1:0] busy_cnt;

    always_comb begin
        gnt_c = 1'b0;
        gnt_l = 1'b0;
        if (busy_cnt == '0) begin
            if (req_c && req_l) begin
                gnt_c = last_l;
                gnt_l = !last_l;
            end else begin
                gnt_c = req_c;
                gnt_l = req_l;
            end
        end
    end

    // Loader only writes, cache only reads
    assign mem_req = gnt_c | gnt_l;
    assign mem_we = gnt_l;
    assign mem_addr = gnt_l ? addr_l : addr_c;
    assign mem_wdata = wdata_l;

    always_ff @(posedge clk) begin
        if (flush_or_rst) begin
            last_l <= 1'b0;
            busy_cnt <= '0;
        end else begin
            if (mem_req) begin
                last_l <= gnt_l;
            end
            if (gnt_c) begin
                busy_cnt <= busy_w'(line_words);
            end else if (mem_rvalid && (busy_cnt != '0)) begin
                busy_cnt <= busy_cnt - 1'b1;
            end
        end
    end

endmodule

//--- hw/main_mem.sv
module main_mem (
    input  logic                       clk,
    input  logic                       mem_req,
    input  logic                       mem_we,
    input  logic [fetch_pkg::xlen-1:0] mem_addr,
    input  logic [fetch_pkg::xlen-1:0] mem_wdata,
    output logic                       mem_rvalid,
    output logic [fetch_pkg::xlen-1:0] mem_rdata
);
    import fetch_pkg::*;

    localparam int word_aw = $clog2(main_mem_words);
    localparam int beat_w = $clog2(line_words) + 1;
    localparam int delay_w = $clog2(mem_read_latency + 1);

    logic [xlen-1:0] mem [main_mem_words];
    logic [word_aw-1:0] rd_ptr;
    logic [beat_w-1:0] beats_left = '0;
    logic [delay_w-1:0] delay_cnt = '0;

    // Streams once the latency delay has run out
    assign mem_rvalid = (beats_left != '0) && (delay_cnt == '0);
    assign mem_rdata = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (mem_req && !mem_we) begin
            rd_ptr <= mem_addr[word_aw+1:2];
            beats_left <= beat_w'(line_words);
            delay_cnt <= delay_w'(mem_read_latency - 1);
        end else if (delay_cnt != '0) begin
            delay_cnt <= delay_cnt - 1'b1;
        end else if (mem_rvalid) begin
            beats_left <= beats_left - 1'b1;
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_req && mem_we) begin
            mem[mem_addr[word_aw+1:2]] <= mem_wdata;
        end
    end

endmodule

//--- hw/fetch_unit.sv
module fetch_unit (
    input  logic                       clk,
    input  logic                       flush_or_rst,
    input  logic                       run,
    input  logic                       redirect,
    input  logic [fetch_pkg::xlen-1:0] redirect_pc,
    output logic                       scr_request,
    output logic [fetch_pkg::xlen-1:0] scr_addr,
    input  logic                       scr_ready,
    input  logic                       scr_data_valid,
    input  logic [fetch_pkg::xlen-1:0] scr_data_out,
    output logic                       cache_request,
    output logic [fetch_pkg::xlen-1:0] cache_addr,
    input  logic                       cache_ready,
    input  logic                       cache_data_valid,
    input  logic [fetch_pkg::xlen-1:0] cache_data_out,
    input  logic                       inst_pop,
    output logic                       inst_valid,
    output logic [fetch_pkg::xlen-1:0] inst_data,
    output logic [fetch_pkg::xlen-1:0] inst_pc
);
    import fetch_pkg::*;

    localparam int credit_w = $clog2(fetch_buf_depth) + 1;

    logic [xlen-1:0] pc;
    logic fifo_flush;
    logic issue;
    logic pop_done;
    logic [credit_w-1:0] credits;
    unit_id_t issue_unit;
    unit_id_t ret_unit;
    logic ret_valid;
    logic [xlen-1:0] ret_data;
    logic [xlen-1:0] pc_q [2];
    logic [1:0] pc_cnt;
    logic pc_wr_slot;
    fetch_entry_t buf_in;
    fetch_entry_t buf_out;

    assign fifo_flush = flush_or_rst | redirect;

    ////////////////////
    // PC and issue

    always_ff @(posedge clk) begin
        if (flush_or_rst) begin
            pc <= reset_vec;
        end else if (redirect) begin
            pc <= {redirect_pc[xlen-1:2], 2'b00};
        end else if (issue) begin
            pc <= pc + 32'd4;
        end
    end

    // Credits cover words in flight plus words sitting in the buffer
    always_ff @(posedge clk) begin
        if (fifo_flush) begin
            credits <= credit_w'(fetch_buf_depth);
        end else begin
            credits <= credits - credit_w'(issue) + credit_w'(pop_done);
        end
    end

    assign pop_done = inst_pop & inst_valid;
    assign issue = run && !redirect && (credits != '0) && scr_ready && cache_ready;
    assign issue_unit = pc[cache_region_bit];

    assign scr_request = issue && !issue_unit;
    assign cache_request = issue && issue_unit;
    assign scr_addr = pc;
    assign cache_addr = pc;

    ////////////////////
    // Sub-unit tracking

    fifo_buffer #(
        .payload_t(unit_id_t),
        .depth(2)
    ) u_unit_fifo (
        .clk(clk),
        .flush_or_rst(fifo_flush),
        .push(issue),
        .pop(ret_valid),
        .data_in(issue_unit),
        .data_out(ret_unit),
        .valid()
    );

    // PCs of words in flight with the oldest in slot zero
    assign pc_wr_slot = 1'(pc_cnt - 2'(ret_valid));

    always_ff @(posedge clk) begin
        if (fifo_flush) begin
            pc_cnt <= '0;
        end else begin
            pc_cnt <= pc_cnt + 2'(issue) - 2'(ret_valid);
        end
    end

    always_ff @(posedge clk) begin
        if (ret_valid) begin
            pc_q[0] <= pc_q[1];
        end
        if (issue) begin
            pc_q[pc_wr_slot] <= pc;
        end
    end

    ////////////////////
    // Instruction buffer

    assign ret_valid = scr_data_valid | cache_data_valid;
    assign ret_data = ret_unit ? cache_data_out : scr_data_out;
    assign buf_in = '{pc: pc_q[0], inst: ret_data};

    fifo_buffer #(
        .payload_t(fetch_entry_t),
        .depth(fetch_buf_depth)
    ) u_inst_buf (
        .clk(clk),
        .flush_or_rst(fifo_flush),
        .push(ret_valid),
        .pop(inst_pop),
        .data_in(buf_in),
        .data_out(buf_out),
        .valid(inst_valid)
    );

    assign inst_data = buf_out.inst;
    assign inst_pc = buf_out.pc;

endmodule

//--- hw/fetch_top.sv
module fetch_top (
    input  logic                       clk,
    input  logic                       flush_or_rst,
    input  logic                       run,
    input  logic                       redirect,
    input  logic [fetch_pkg::xlen-1:0] redirect_pc,
    input  logic                       inst_pop,
    output logic                       inst_valid,
    output logic [fetch_pkg::xlen-1:0] inst_data,
    output logic [fetch_pkg::xlen-1:0] inst_pc,
    input  logic                       scr_load_we,
    input  logic [fetch_pkg::xlen-1:0] scr_load_addr,
    input  logic [fetch_pkg::xlen-1:0] scr_load_data,
    input  logic                       load_req,
    input  logic [fetch_pkg::xlen-1:0] load_addr,
    input  logic [fetch_pkg::xlen-1:0] load_data,
    output logic                       load_gnt
);
    import fetch_pkg::*;

    // Fetch side
    logic scr_request;
    logic [xlen-1:0] scr_addr;
    logic scr_ready;
    logic scr_data_valid;
    logic [xlen-1:0] scr_data_out;
    logic cache_request;
    logic [xlen-1:0] cache_addr;
    logic cache_ready;
    logic cache_data_valid;
    logic [xlen-1:0] cache_data_out;

    // Shared memory bus
    logic bus_req;
    logic [xlen-1:0] bus_addr;
    logic bus_gnt;
    logic mem_req;
    logic mem_we;
    logic [xlen-1:0] mem_addr;
    logic [xlen-1:0] mem_wdata;
    logic mem_rvalid;
    logic [xlen-1:0] mem_rdata;

    fetch_unit u_fetch_unit (.*);

    iscratch_mem u_iscratch_mem (
        .clk(clk),
        .flush_or_rst(flush_or_rst),
        .request(scr_request),
        .addr(scr_addr),
        .ready(scr_ready),
        .data_valid(scr_data_valid),
        .data_out(scr_data_out),
        .load_we(scr_load_we),
        .load_addr(scr_load_addr),
        .load_data(scr_load_data)
    );

    icache u_icache (
        .clk(clk),
        .flush_or_rst(flush_or_rst),
        .redirect(redirect),
        .request(cache_request),
        .addr(cache_addr),
        .ready(cache_ready),
        .data_valid(cache_data_valid),
        .data_out(cache_data_out),
        .bus_req(bus_req),
        .bus_addr(bus_addr),
        .bus_gnt(bus_gnt),
        .rvalid(mem_rvalid),
        .rdata(mem_rdata)
    );

    mem_arbiter u_mem_arbiter (
        .clk(clk),
        .flush_or_rst(flush_or_rst),
        .req_c(bus_req),
        .addr_c(bus_addr),
        .gnt_c(bus_gnt),
        .req_l(load_req),
        .addr_l(load_addr),
        .wdata_l(load_data),
        .gnt_l(load_gnt),
        .mem_req(mem_req),
        .mem_we(mem_we),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .mem_rvalid(mem_rvalid)
    );

    main_mem u_main_mem (.*);

endmodule

//--- sim/tb_fetch_top.sv
module tb_fetch_top;
    import fetch_pkg::*;

    localparam int gnt_timeout = 40;

    logic clk;
    logic flush_or_rst;
    logic run;
    logic redirect;
    logic [xlen-1:0] redirect_pc;
    logic inst_pop;
    logic inst_valid;
    logic [xlen-1:0] inst_data;
    logic [xlen-1:0] inst_pc;
    logic scr_load_we;
    logic [xlen-1:0] scr_load_addr;
    logic [xlen-1:0] scr_load_data;
    logic load_req;
    logic [xlen-1:0] load_addr;
    logic [xlen-1:0] load_data;
    logic load_gnt;

    // Shadow copies of both memories
    logic [xlen-1:0] scratch_shadow [scratch_words];
    logic [xlen-1:0] main_shadow [main_mem_words];
    logic [xlen-1:0] fresh_words [16];

    integer seed;
    logic [31:0] load_rnd;
    logic [31:0] pop_rnd;
    logic random_pop;
    logic [xlen-1:0] exp_pc;
    logic [xlen-1:0] exp_word;
    int words_seen;

    fetch_top u_fetch_top (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////
    // Helpers

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    // Expected word for a fetch address, region by bit 31, both spaces wrap
    function automatic logic [xlen-1:0] expected_word(input logic [xlen-1:0] pc);
        if (pc[cache_region_bit]) begin
            return main_shadow[(pc >> 2) % main_mem_words];
        end
        return scratch_shadow[(pc >> 2) % scratch_words];
    endfunction

    // Single-word write through the shared bus, request held until granted
    task automatic main_write(input logic [xlen-1:0] addr, input logic [xlen-1:0] data);
        int cycles;
        cycles = 0;
        @(negedge clk);
        load_req = 1'b1;
        load_addr = addr;
        load_data = data;
        @(posedge clk);
        while (!load_gnt) begin
            cycles++;
            if (cycles > gnt_timeout) begin
                abort_run($sformatf("timeout waiting for load_gnt at address %h", addr));
            end
            @(posedge clk);
        end
    endtask

    task automatic wait_words(input int n, input string what);
        int target;
        int cycles;
        target = words_seen + n;
        cycles = 0;
        while (words_seen < target) begin
            @(negedge clk);
            cycles++;
            if (cycles > 40 * n + 100) begin
                abort_run($sformatf("timeout waiting for %0d words during %s", n, what));
            end
        end
    endtask

    task automatic redirect_to(input logic [xlen-1:0] pc);
        @(negedge clk);
        redirect = 1'b1;
        redirect_pc = pc;
        @(negedge clk);
        redirect = 1'b0;
    endtask

    // Mode changes on the rising edge so the pop driver sees them cleanly
    task automatic set_pop_random(input logic on);
        @(posedge clk);
        random_pop = on;
        if (!on) begin
            @(negedge clk);
            inst_pop = 1'b1;
        end
    endtask

    ////////////////////
    // Pop driver and compare

    always @(negedge clk) begin
        if (random_pop) begin
            pop_rnd = $random(seed);
            inst_pop = pop_rnd[0];
        end
    end

    always @(posedge clk) begin
        if (flush_or_rst) begin
            exp_pc = reset_vec;
        end else begin
            if (inst_valid && inst_pop) begin
                exp_word = expected_word(exp_pc);
                assert (inst_pc == exp_pc) else begin
                    abort_run($sformatf("ERR inst_pc got %h expected %h", inst_pc, exp_pc));
                end
                assert (inst_data == exp_word) else begin
                    abort_run($sformatf("ERR inst_data got %h expected %h at pc %h",
                        inst_data, exp_word, exp_pc));
                end
                exp_pc = exp_pc + 32'd4;
                words_seen++;
            end
            // Stream restarts at the new PC after the flush edge
            if (redirect) begin
                exp_pc = redirect_pc;
            end
        end
    end

    ////////////////////
    // Stimulus

    initial begin
        seed = 32'h2f0bf04e;
        flush_or_rst = 1'b1;
        run = 1'b0;
        redirect = 1'b0;
        redirect_pc = '0;
        inst_pop = 1'b0;
        scr_load_we = 1'b0;
        scr_load_addr = '0;
        scr_load_data = '0;
        load_req = 1'b0;
        load_addr = '0;
        load_data = '0;
        random_pop = 1'b0;
        words_seen = 0;
        exp_pc = reset_vec;
        repeat (3) @(negedge clk);
        flush_or_rst = 1'b0;

        // Program loading while the core is held
        for (int i = 0; i < scratch_words; i++) begin
            @(negedge clk);
            load_rnd = $random(seed);
            scr_load_we = 1'b1;
            scr_load_addr = i * 4;
            scr_load_data = load_rnd;
            scratch_shadow[i] = load_rnd;
        end
        @(negedge clk);
        scr_load_we = 1'b0;
        for (int i = 0; i < main_mem_words; i++) begin
            load_rnd = $random(seed);
            main_write(i * 4, load_rnd);
            main_shadow[i] = load_rnd;
        end
        @(negedge clk);
        load_req = 1'b0;
        for (int i = 0; i < 16; i++) begin
            fresh_words[i] = $random(seed);
        end

        // Sequential scratch fetch from the reset vector
        @(negedge clk);
        run = 1'b1;
        inst_pop = 1'b1;
        wait_words(16, "scratch fetch from reset");

        // Cache space, misses then hits in each line
        redirect_to(32'h8000_0000);
        wait_words(32, "cache fetch");

        set_pop_random(1'b1);
        wait_words(48, "random pop back-pressure");
        set_pop_random(1'b0);

        // Second redirect lands while the first miss is still pending
        redirect_to(32'h8000_0600);
        redirect_to(32'h0000_0040);
        wait_words(8, "redirect over a pending miss");

        // Loader writes unfetched lines while the cache keeps refilling
        redirect_to(32'h8000_0400);
        fork
            begin
                for (int k = 0; k < 16; k++) begin
                    main_write(32'h8000_0800 + k * 4, fresh_words[k]);
                    main_shadow[512 + k] = fresh_words[k];
                end
                @(negedge clk);
                load_req = 1'b0;
            end
            wait_words(8, "refill beside loader writes");
        join
        redirect_to(32'h8000_0800);
        wait_words(16, "fetch of freshly loaded lines");

        // Scratch address past the memory depth
        redirect_to(32'h0000_0F00);
        wait_words(12, "scratch wrap-around");

        @(negedge clk);
        run = 1'b0;
        repeat (4) @(negedge clk);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- files.f
hw/fetch_pkg.sv
hw/fifo_buffer.sv
hw/iscratch_mem.sv
hw/icache.sv
hw/mem_arbiter.sv
hw/main_mem.sv
hw/fetch_unit.sv
hw/fetch_top.sv
sim/tb_fetch_top.sv

//--- Bender.yml
package:
  name: fetch_top

sources:
  - hw/fetch_pkg.sv
  - hw/fifo_buffer.sv
  - hw/iscratch_mem.sv
  - hw/icache.sv
  - hw/mem_arbiter.sv
  - hw/main_mem.sv
  - hw/fetch_unit.sv
  - hw/fetch_top.sv
  - target: test
    files:
      - sim/tb_fetch_top.sv
